// File: verilog/stepper_pkg.sv
package stepper_pkg;

  // bus words and addresses
  typedef logic [31:0] word_t;
  typedef logic [31:0] bus_addr_t;

  // register index, offset from PERIPH_BASE in words
  typedef logic [3:0] reg_sel_t;

  localparam bus_addr_t PERIPH_BASE = 32'h1000_0000;
  localparam int PERIPH_WORDS = 10;

  localparam reg_sel_t REG_LED           = 4'd0;
  localparam reg_sel_t REG_SPI_OUT_UP    = 4'd1;
  localparam reg_sel_t REG_SPI_OUT_LOW   = 4'd2;
  localparam reg_sel_t REG_SPI_IN_UP     = 4'd3;
  localparam reg_sel_t REG_SPI_IN_LOW    = 4'd4;
  localparam reg_sel_t REG_SPI_CONFIG    = 4'd5;
  localparam reg_sel_t REG_SPI_STATUS    = 4'd6;
  localparam reg_sel_t REG_STEP_CTRL_UP  = 4'd7;
  localparam reg_sel_t REG_STEP_CTRL_LOW = 4'd8;
  localparam reg_sel_t REG_STEP_STATUS   = 4'd9;
  localparam reg_sel_t REG_NONE          = 4'd15;

  // slots of the writable register array
  localparam int CTRL_WORDS     = 6;
  localparam int CW_LED         = 0;
  localparam int CW_SPI_OUT_UP  = 1;
  localparam int CW_SPI_OUT_LOW = 2;
  localparam int CW_SPI_CONFIG  = 3;
  localparam int CW_STEP_UP     = 4;
  localparam int CW_STEP_LOW    = 5;

  // spi master
  localparam int SPI_BITS     = 40;
  localparam int SPI_CS_COUNT = 12;
  localparam int SPI_CLK_DIV  = 4;
  typedef logic [SPI_BITS-1:0] spi_frame_t;
  typedef logic [3:0] cs_sel_t;
  typedef logic [SPI_CS_COUNT-1:0] cs_lines_t;

  // step generator
  typedef logic [30:0] step_count_t;

  typedef enum logic [1:0] {spi_idle, spi_shift, spi_finish} spi_state_t;
  typedef enum logic [1:0] {step_idle, step_high, step_low} step_state_t;

endpackage

// File: verilog/reg_bus_if.sv
`timescale 1ns/10ps

// one decoded register access from the bus decoder
interface reg_bus_if;

  stepper_pkg::reg_sel_t sel;
  logic write_stb;
  logic read_stb;
  stepper_pkg::word_t wdata;

  modport decoder (
    output sel,
    output write_stb,
    output read_stb,
    output wdata
  );

  // register file only needs the write side
  modport regs (
    input sel,
    input write_stb,
    input wdata
  );

  modport reader (
    input sel,
    input read_stb
  );

endinterface

// File: verilog/bus_decode.sv
`timescale 1ns/10ps

module bus_decode (
  input  logic                   clk_in,
  input  logic                   reset,
  input  logic                   mem_valid,
  input  stepper_pkg::bus_addr_t mem_addr,
  input  stepper_pkg::word_t     mem_wdata,
  input  logic [3:0]             mem_wstrb,
  output logic                   mem_ready,
  reg_bus_if.decoder             bus
);

  logic                   busy;
  logic                   mapped;
  logic                   accept;
  stepper_pkg::bus_addr_t offset;
  stepper_pkg::reg_sel_t  addr_sel;

  // range check against the peripheral window
  assign offset = mem_addr - stepper_pkg::PERIPH_BASE;
  assign mapped = (mem_addr >= stepper_pkg::PERIPH_BASE) &&
                  (offset < stepper_pkg::bus_addr_t'(stepper_pkg::PERIPH_WORDS * 4));
  assign addr_sel = mapped ? stepper_pkg::reg_sel_t'(offset[5:2]) : stepper_pkg::REG_NONE;

  // first cycle of a request not yet served
  assign accept = mem_valid && !busy;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      busy          <= 1'b0;
      mem_ready     <= 1'b0;
      bus.sel       <= stepper_pkg::REG_NONE;
      bus.write_stb <= 1'b0;
      bus.read_stb  <= 1'b0;
    end else begin
      // strobes are single cycle, ready follows one cycle later
      bus.write_stb <= 1'b0;
      bus.read_stb  <= 1'b0;
      mem_ready     <= bus.write_stb | bus.read_stb;
      if (!mem_valid) begin
        busy <= 1'b0;
      end else if (accept) begin
        busy          <= 1'b1;
        bus.sel       <= addr_sel;
        bus.write_stb <= |mem_wstrb;
        bus.read_stb  <= ~|mem_wstrb;
      end
    end
  end

  // full word writes only
  always_ff @(posedge clk_in) begin
    if (accept) begin
      bus.wdata <= mem_wdata;
    end
  end

endmodule

// File: verilog/ctrl_regs.sv
`timescale 1ns/10ps

module ctrl_regs (
  input  logic                     clk_in,
  input  logic                     reset,
  reg_bus_if.regs                  bus,
  output logic [3:0]               led,
  output stepper_pkg::spi_frame_t  spi_out,
  output logic                     spi_send,
  output stepper_pkg::cs_sel_t     spi_cs_sel,
  output stepper_pkg::word_t       step_half_period,
  output stepper_pkg::step_count_t step_count,
  output logic                     step_enable,
  output stepper_pkg::word_t       ctrl_words [stepper_pkg::CTRL_WORDS]
);

  stepper_pkg::word_t regs_q [stepper_pkg::CTRL_WORDS];

  always_ff @(posedge clk_in) begin
    if (reset) begin
      for (int i = 0; i < stepper_pkg::CTRL_WORDS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (bus.write_stb) begin
      // read-only and unmapped selects fall through
      case (bus.sel)
        stepper_pkg::REG_LED:
          regs_q[stepper_pkg::CW_LED] <= bus.wdata;
        stepper_pkg::REG_SPI_OUT_UP:
          regs_q[stepper_pkg::CW_SPI_OUT_UP] <= bus.wdata;
        stepper_pkg::REG_SPI_OUT_LOW:
          regs_q[stepper_pkg::CW_SPI_OUT_LOW] <= bus.wdata;
        stepper_pkg::REG_SPI_CONFIG:
          regs_q[stepper_pkg::CW_SPI_CONFIG] <= bus.wdata;
        stepper_pkg::REG_STEP_CTRL_UP:
          regs_q[stepper_pkg::CW_STEP_UP] <= bus.wdata;
        stepper_pkg::REG_STEP_CTRL_LOW:
          regs_q[stepper_pkg::CW_STEP_LOW] <= bus.wdata;
        default: ;
      endcase
    end
  end

  assign led = regs_q[stepper_pkg::CW_LED][3:0];

  // 40-bit frame, upper byte from the upper register
  assign spi_out = {regs_q[stepper_pkg::CW_SPI_OUT_UP][7:0],
                    regs_q[stepper_pkg::CW_SPI_OUT_LOW]};

  // config: 4:1 chip select, 0 send
  assign spi_send   = regs_q[stepper_pkg::CW_SPI_CONFIG][0];
  assign spi_cs_sel = regs_q[stepper_pkg::CW_SPI_CONFIG][4:1];

  // control lower: 31:1 pulse count, 0 enable
  assign step_half_period = regs_q[stepper_pkg::CW_STEP_UP];
  assign step_count       = regs_q[stepper_pkg::CW_STEP_LOW][31:1];
  assign step_enable      = regs_q[stepper_pkg::CW_STEP_LOW][0];

  assign ctrl_words = regs_q;

endmodule

// File: verilog/spi_master.sv
`timescale 1ns/10ps

module spi_master (
  input  logic                    clk_in,
  input  logic                    reset,
  input  stepper_pkg::spi_frame_t data_in,
  input  logic                    send,
  input  stepper_pkg::cs_sel_t    cs_sel,
  input  logic                    miso,
  output logic                    sck,
  output logic                    mosi,
  output stepper_pkg::cs_lines_t  cs_n,
  output logic                    ready,
  output stepper_pkg::spi_frame_t data_out
);

  localparam int BIT_W = $clog2(stepper_pkg::SPI_BITS);
  localparam int DIV_W = $clog2(stepper_pkg::SPI_CLK_DIV);

  stepper_pkg::spi_state_t state;
  stepper_pkg::spi_frame_t tx_shift;
  stepper_pkg::spi_frame_t rx_shift;
  logic [BIT_W-1:0]        bit_cnt;
  logic [DIV_W-1:0]        div_cnt;
  logic                    send_q;
  logic                    start;
  logic                    half_done;

  assign start     = send && !send_q && ready;
  assign half_done = (div_cnt == DIV_W'(stepper_pkg::SPI_CLK_DIV - 1));

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state    <= stepper_pkg::spi_idle;
      send_q   <= 1'b0;
      sck      <= 1'b0;
      mosi     <= 1'b0;
      cs_n     <= '1;
      ready    <= 1'b1;
      bit_cnt  <= '0;
      div_cnt  <= '0;
      data_out <= '0;
    end else begin
      send_q <= send;
      case (state)
        stepper_pkg::spi_idle: begin
          if (start) begin
            ready   <= 1'b0;
            bit_cnt <= '0;
            div_cnt <= '0;
            mosi    <= data_in[stepper_pkg::SPI_BITS-1];
            // selections past the last line keep all lines high
            if (cs_sel < stepper_pkg::SPI_CS_COUNT) begin
              cs_n <= ~(stepper_pkg::cs_lines_t'(1) << cs_sel);
            end
            state <= stepper_pkg::spi_shift;
          end
        end
        stepper_pkg::spi_shift: begin
          if (!half_done) begin
            div_cnt <= div_cnt + 1'b1;
          end else begin
            div_cnt <= '0;
            if (!sck) begin
              // sample on the rising sck edge
              sck <= 1'b1;
            end else begin
              sck <= 1'b0;
              if (bit_cnt == BIT_W'(stepper_pkg::SPI_BITS - 1)) begin
                state <= stepper_pkg::spi_finish;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
                mosi    <= tx_shift[stepper_pkg::SPI_BITS-2];
              end
            end
          end
        end
        stepper_pkg::spi_finish: begin
          cs_n     <= '1;
          mosi     <= 1'b0;
          data_out <= rx_shift;
          ready    <= 1'b1;
          state    <= stepper_pkg::spi_idle;
        end
        default: state <= stepper_pkg::spi_idle;
      endcase
    end
  end

  // shift registers, msb first
  always_ff @(posedge clk_in) begin
    if (start) begin
      tx_shift <= data_in;
    end else if (state == stepper_pkg::spi_shift && half_done) begin
      if (!sck) begin
        rx_shift <= {rx_shift[stepper_pkg::SPI_BITS-2:0], miso};
      end else begin
        tx_shift <= {tx_shift[stepper_pkg::SPI_BITS-2:0], 1'b0};
      end
    end
  end

endmodule

// File: verilog/step_generator.sv
`timescale 1ns/10ps

module step_generator (
  input  logic                     clk_in,
  input  logic                     reset,
  input  logic                     enable,
  input  stepper_pkg::word_t       half_period,
  input  stepper_pkg::step_count_t count,
  output logic                     step,
  output logic                     done
);

  stepper_pkg::step_state_t state;
  stepper_pkg::step_count_t remaining;
  stepper_pkg::word_t       period;
  stepper_pkg::word_t       cyc;
  logic                     enable_q;
  logic                     phase_end;

  assign phase_end = (cyc == period - 1'b1);

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state     <= stepper_pkg::step_idle;
      enable_q  <= 1'b0;
      step      <= 1'b0;
      done      <= 1'b0;
      remaining <= '0;
      period    <= 32'd1;
      cyc       <= '0;
    end else begin
      enable_q <= enable;
      case (state)
        stepper_pkg::step_idle: begin
          // new run only on a rising enable
          if (enable && !enable_q) begin
            remaining <= count;
            period    <= (half_period == '0) ? 32'd1 : half_period;
            cyc       <= '0;
            if (count == '0) begin
              done <= 1'b1;
            end else begin
              done  <= 1'b0;
              step  <= 1'b1;
              state <= stepper_pkg::step_high;
            end
          end
        end
        stepper_pkg::step_high: begin
          if (phase_end) begin
            cyc   <= '0;
            step  <= 1'b0;
            state <= stepper_pkg::step_low;
          end else begin
            cyc <= cyc + 1'b1;
          end
        end
        stepper_pkg::step_low: begin
          if (!phase_end) begin
            cyc <= cyc + 1'b1;
          end else if (remaining == stepper_pkg::step_count_t'(1)) begin
            done  <= 1'b1;
            state <= stepper_pkg::step_idle;
          end else begin
            cyc       <= '0;
            remaining <= remaining - 1'b1;
            step      <= 1'b1;
            state     <= stepper_pkg::step_high;
          end
        end
        default: state <= stepper_pkg::step_idle;
      endcase
    end
  end

endmodule

// File: verilog/read_return.sv
`timescale 1ns/10ps

module read_return (
  input  logic                    clk_in,
  input  logic                    reset,
  reg_bus_if.reader               bus,
  input  stepper_pkg::word_t      ctrl_words [stepper_pkg::CTRL_WORDS],
  input  stepper_pkg::spi_frame_t spi_in,
  input  logic                    spi_ready,
  input  logic                    step_done,
  output stepper_pkg::word_t      mem_rdata
);

  // rdata lines up with mem_ready, zero otherwise
  always_ff @(posedge clk_in) begin
    if (reset) begin
      mem_rdata <= '0;
    end else if (bus.read_stb) begin
      case (bus.sel)
        stepper_pkg::REG_LED:
          mem_rdata <= ctrl_words[stepper_pkg::CW_LED];
        stepper_pkg::REG_SPI_OUT_UP:
          mem_rdata <= ctrl_words[stepper_pkg::CW_SPI_OUT_UP];
        stepper_pkg::REG_SPI_OUT_LOW:
          mem_rdata <= ctrl_words[stepper_pkg::CW_SPI_OUT_LOW];
        stepper_pkg::REG_SPI_IN_UP:
          mem_rdata <= stepper_pkg::word_t'(spi_in[stepper_pkg::SPI_BITS-1:32]);
        stepper_pkg::REG_SPI_IN_LOW:
          mem_rdata <= spi_in[31:0];
        stepper_pkg::REG_SPI_CONFIG:
          mem_rdata <= ctrl_words[stepper_pkg::CW_SPI_CONFIG];
        stepper_pkg::REG_SPI_STATUS:
          mem_rdata <= stepper_pkg::word_t'(spi_ready);
        stepper_pkg::REG_STEP_CTRL_UP:
          mem_rdata <= ctrl_words[stepper_pkg::CW_STEP_UP];
        stepper_pkg::REG_STEP_CTRL_LOW:
          mem_rdata <= ctrl_words[stepper_pkg::CW_STEP_LOW];
        stepper_pkg::REG_STEP_STATUS:
          mem_rdata <= stepper_pkg::word_t'(step_done);
        default:
          mem_rdata <= '0;
      endcase
    end else begin
      mem_rdata <= '0;
    end
  end

endmodule

// File: verilog/stepper_io.sv
`timescale 1ns/10ps

module stepper_io (
  input  logic                   clk_in,
  input  logic                   reset,
  input  logic                   mem_valid,
  input  stepper_pkg::bus_addr_t mem_addr,
  input  stepper_pkg::word_t     mem_wdata,
  input  logic [3:0]             mem_wstrb,
  output stepper_pkg::word_t     mem_rdata,
  output logic                   mem_ready,
  output logic [3:0]             led,
  input  logic                   spi_miso,
  output logic                   spi_sck,
  output logic                   spi_mosi,
  output stepper_pkg::cs_lines_t spi_cs_n,
  output logic                   step
);

  stepper_pkg::spi_frame_t  spi_out;
  stepper_pkg::spi_frame_t  spi_in;
  stepper_pkg::cs_sel_t     spi_cs_sel;
  stepper_pkg::word_t       step_half_period;
  stepper_pkg::step_count_t step_count;
  stepper_pkg::word_t       ctrl_words [stepper_pkg::CTRL_WORDS];
  logic                     spi_send;
  logic                     spi_ready;
  logic                     step_enable;
  logic                     step_done;

  reg_bus_if reg_bus ();

  // decode
  bus_decode i_bus_decode (
    .clk_in   (clk_in),
    .reset    (reset),
    .mem_valid(mem_valid),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_ready(mem_ready),
    .bus      (reg_bus)
  );

  // execute
  ctrl_regs i_ctrl_regs (
    .clk_in          (clk_in),
    .reset           (reset),
    .bus             (reg_bus),
    .led             (led),
    .spi_out         (spi_out),
    .spi_send        (spi_send),
    .spi_cs_sel      (spi_cs_sel),
    .step_half_period(step_half_period),
    .step_count      (step_count),
    .step_enable     (step_enable),
    .ctrl_words      (ctrl_words)
  );

  spi_master i_spi_master (
    .clk_in  (clk_in),
    .reset   (reset),
    .data_in (spi_out),
    .send    (spi_send),
    .cs_sel  (spi_cs_sel),
    .miso    (spi_miso),
    .sck     (spi_sck),
    .mosi    (spi_mosi),
    .cs_n    (spi_cs_n),
    .ready   (spi_ready),
    .data_out(spi_in)
  );

  step_generator i_step_generator (
    .clk_in     (clk_in),
    .reset      (reset),
    .enable     (step_enable),
    .half_period(step_half_period),
    .count      (step_count),
    .step       (step),
    .done       (step_done)
  );

  // result
  read_return i_read_return (
    .clk_in    (clk_in),
    .reset     (reset),
    .bus       (reg_bus),
    .ctrl_words(ctrl_words),
    .spi_in    (spi_in),
    .spi_ready (spi_ready),
    .step_done (step_done),
    .mem_rdata (mem_rdata)
  );

endmodule

// File: tb/stepper_io_assert.sv
`timescale 1ns/10ps

module stepper_io_assert (
  input logic                   clk_in,
  input logic                   reset,
  input logic                   mem_valid,
  input logic                   mem_ready,
  input stepper_pkg::cs_lines_t spi_cs_n,
  input logic                   spi_sck,
  input logic                   spi_ready,
  input logic                   step,
  input logic                   step_done
);

  // ready is a single pulse
  assert property (@(posedge clk_in) disable iff (reset) mem_ready |=> !mem_ready)
    else $error("mem_ready held for more than one cycle");

  // two cycles of valid before ready
  assert property (@(posedge clk_in) disable iff (reset)
    mem_ready |-> mem_valid && $past(mem_valid) && $past(mem_valid, 2))
    else $error("mem_ready without a held mem_valid");

  assert property (@(posedge clk_in) disable iff (reset) $onehot0(~spi_cs_n))
    else $error("more than one chip select low");

  // selection 12 clocks with all lines high, so only idle counts
  assert property (@(posedge clk_in) disable iff (reset)
    (&spi_cs_n && spi_ready) |-> !spi_sck)
    else $error("sck toggling while no device is selected");

  assert property (@(posedge clk_in) disable iff (reset) step_done |-> !step)
    else $error("step pulse while done is set");

endmodule

bind stepper_io stepper_io_assert i_stepper_io_assert (
  .clk_in   (clk_in),
  .reset    (reset),
  .mem_valid(mem_valid),
  .mem_ready(mem_ready),
  .spi_cs_n (spi_cs_n),
  .spi_sck  (spi_sck),
  .spi_ready(spi_ready),
  .step     (step),
  .step_done(step_done)
);

// File: tb/tb_stepper_io.sv
`timescale 1ns/10ps

module tb_stepper_io;

  localparam int BUS_TIMEOUT = 20;
  localparam int POLL_LIMIT  = 200;
  localparam int SCK_PULSES  = 40;

  logic                   clk_in = 1'b0;
  logic                   reset;
  logic                   mem_valid;
  stepper_pkg::bus_addr_t mem_addr;
  stepper_pkg::word_t     mem_wdata;
  logic [3:0]             mem_wstrb;
  stepper_pkg::word_t     mem_rdata;
  logic                   mem_ready;
  logic [3:0]             led;
  logic                   spi_sck;
  logic                   spi_mosi;
  stepper_pkg::cs_lines_t spi_cs_n;
  logic                   step;

  int unsigned            lcg_state = 14;
  stepper_pkg::cs_lines_t cs_seen;
  int                     step_edges;
  logic                   step_prev;
  int                     sck_edges;
  logic                   sck_prev;

  // miso looped back from mosi
  stepper_io i_dut (
    .clk_in   (clk_in),
    .reset    (reset),
    .mem_valid(mem_valid),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .led      (led),
    .spi_miso (spi_mosi),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_cs_n (spi_cs_n),
    .step     (step)
  );

  always #4 clk_in = ~clk_in;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input stepper_pkg::word_t actual, input stepper_pkg::word_t expected,
                             input string what);
    if (actual !== expected) begin
      fail_run($sformatf("error: %0t ns %s: got %h, expected %h", $time, what, actual, expected));
    end
  endtask

  // one falling edge; also tracks chip selects, sck and step pulses
  task automatic tick();
    @(negedge clk_in);
    cs_seen = cs_seen & spi_cs_n;
    if (step && !step_prev) begin
      step_edges++;
    end
    step_prev = step;
    if (spi_sck && !sck_prev) begin
      sck_edges++;
    end
    sck_prev = spi_sck;
  endtask

  task automatic bus_access(input stepper_pkg::bus_addr_t addr, input stepper_pkg::word_t data,
                            input logic write, output stepper_pkg::word_t rdata);
    int waited;
    int gap;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = data;
    mem_wstrb = write ? 4'hf : 4'h0;
    waited    = 0;
    tick();
    while (!mem_ready) begin
      waited++;
      if (waited > BUS_TIMEOUT) begin
        fail_run($sformatf("no mem_ready for access to %h", addr));
      end
      tick();
    end
    rdata = mem_rdata;
    // hold the request through the edge that samples ready
    tick();
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
    // valid stays low for at least one cycle
    gap = int'((lcg_next() >> 16) % 4) + 1;
    repeat (gap) tick();
  endtask

  initial begin
    int                     fd;
    int                     fields;
    int                     polls;
    string                  line;
    string                  op;
    stepper_pkg::bus_addr_t addr;
    stepper_pkg::word_t     data;
    stepper_pkg::word_t     mask;
    stepper_pkg::word_t     rdata;
    logic                   matched;

    reset      = 1'b1;
    mem_valid  = 1'b0;
    mem_addr   = '0;
    mem_wdata  = '0;
    mem_wstrb  = 4'h0;
    step_edges = 0;
    step_prev  = 1'b0;
    sck_edges  = 0;
    sck_prev   = 1'b0;
    cs_seen    = '1;
    repeat (5) @(negedge clk_in);
    reset     = 1'b0;
    step_prev = step;
    sck_prev  = spi_sck;
    cs_seen   = '1;

    fd = $fopen("tb/stepper_patterns.txt", "r");
    if (fd == 0) begin
      fail_run("could not open tb/stepper_patterns.txt");
    end
    while (!$feof(fd)) begin
      line   = "";
      fields = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      fields = $sscanf(line, "%s %h %h %h", op, addr, data, mask);
      if (fields != 4) begin
        fail_run($sformatf("malformed pattern line: %s", line));
      end
      if (op == "wr") begin
        bus_access(addr, data, 1'b1, rdata);
      end else if (op == "rd") begin
        bus_access(addr, '0, 1'b0, rdata);
        check_value(rdata & mask, data & mask, $sformatf("read of %h", addr));
      end else if (op == "poll") begin
        matched = 1'b0;
        polls   = 0;
        while (!matched) begin
          if (polls >= POLL_LIMIT) begin
            fail_run($sformatf("poll of %h never reached %h", addr, data & mask));
          end
          bus_access(addr, '0, 1'b0, rdata);
          matched = ((rdata & mask) == (data & mask));
          polls++;
        end
      end else if (op == "steps") begin
        check_value(stepper_pkg::word_t'(step_edges), data, "step pulse count");
        step_edges = 0;
      end else if (op == "cs") begin
        // low bits mark lines never seen low since the last check
        check_value(stepper_pkg::word_t'(cs_seen), data & mask, "chip selects seen low");
        cs_seen = '1;
        // one transfer since the last check, one sck pulse per bit
        check_value(stepper_pkg::word_t'(sck_edges), stepper_pkg::word_t'(SCK_PULSES),
                    "sck pulses in one transfer");
        sck_edges = 0;
      end else if (op == "led") begin
        check_value(stepper_pkg::word_t'(led), data & mask, "led port");
      end else begin
        fail_run($sformatf("unknown pattern operation %s", op));
      end
    end
    $fclose(fd);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: tb/stepper_patterns.txt
# columns: op addr data mask, all hex
# ops: wr rd poll steps cs led
rd 10000018 00000001 ffffffff
rd 10000024 00000000 ffffffff
rd 10000000 00000000 ffffffff
rd 10000004 00000000 ffffffff
rd 10000008 00000000 ffffffff
rd 10000014 00000000 ffffffff
rd 1000001c 00000000 ffffffff
rd 10000020 00000000 ffffffff
wr 10000000 0000005a 00000000
led 00000000 0000000a 0000000f
rd 10000000 0000005a ffffffff
wr 10000004 000000a5 00000000
wr 10000008 3c5a9617 00000000
rd 10000004 000000a5 ffffffff
rd 10000008 3c5a9617 ffffffff
wr 1000001c 00000003 00000000
rd 1000001c 00000003 ffffffff
wr 10000018 00000000 00000000
rd 10000018 00000001 ffffffff
wr 10000024 ffffffff 00000000
rd 10000024 00000000 ffffffff
wr 1000000c 12345678 00000000
rd 1000000c 00000000 ffffffff
wr 10000010 87654321 00000000
rd 10000010 00000000 ffffffff
wr 10000028 deadbeef 00000000
rd 10000028 00000000 ffffffff
wr 20000000 00000007 00000000
rd 20000000 00000000 ffffffff
rd 10000000 0000005a ffffffff
wr 10000014 00000007 00000000
poll 10000018 00000001 00000001
rd 1000000c 000000a5 ffffffff
rd 10000010 3c5a9617 ffffffff
cs 00000000 00000ff7 00000fff
wr 10000014 00000000 00000000
wr 10000004 0000ff3c 00000000
wr 10000008 80000001 00000000
wr 10000014 00000019 00000000
poll 10000018 00000001 00000001
rd 1000000c 0000003c ffffffff
rd 10000010 80000001 ffffffff
cs 00000000 00000fff 00000fff
wr 10000014 00000000 00000000
wr 10000020 0000000b 00000000
poll 10000024 00000001 00000001
steps 00000000 00000005 00000000
rd 10000020 0000000b ffffffff
wr 10000020 00000000 00000000
wr 1000001c 00000000 00000000
wr 10000020 00000007 00000000
poll 10000024 00000001 00000001
steps 00000000 00000003 00000000
wr 10000020 00000000 00000000
wr 10000020 00000001 00000000
poll 10000024 00000001 00000001
steps 00000000 00000000 00000000

// File: files.f
verilog/stepper_pkg.sv
verilog/reg_bus_if.sv
verilog/bus_decode.sv
verilog/ctrl_regs.sv
verilog/spi_master.sv
verilog/step_generator.sv
verilog/read_return.sv
verilog/stepper_io.sv
tb/stepper_io_assert.sv
tb/tb_stepper_io.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_stepper_io
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
